// ==== Bender.yml ====
package:
  name: lsu

export_include_dirs:
  - hw

sources:
  - files:
      - hw/lsu_pkg.sv
      - hw/lsu_decode.sv
      - hw/lsu_tag_lookup.sv
      - hw/lsu_data_array.sv
      - hw/lsu_result.sv
      - hw/lsu_top.sv
  - target: test
    files:
      - tests/lsu_chk.sv
      - tests/lsu_monitor.sv
      - tests/tb_lsu.sv

// ==== hw/lsu_cfg.svh ====
// LSU configuration: address, data, ROB tag and data cache geometry widths
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

`define LSU_ADDR_W      32
`define LSU_DATA_W      32
`define LSU_ROB_TAG_W   6

// Data cache geometry: 32-byte lines, 16 sets, 2 ways
`define LSU_DC_LINE_W   5
`define LSU_DC_INDEX_W  4
`define LSU_DC_WAY_W    1
`define LSU_DC_WAYS     2

// Tag bits left above index and byte offset
`define LSU_DC_TAG_W    (`LSU_ADDR_W - `LSU_DC_INDEX_W - `LSU_DC_LINE_W)

`endif

// ==== hw/lsu_data_array.sv ====
// LSU data array: cache words written by store hits and refills, read for loads
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_data_array import lsu_pkg::*; (
    input  logic                       clk,
    input  lsu_stage_t                 i_stage,
    input  lsu_refill_t                i_refill,
    input  logic [`LSU_DC_WAY_W-1:0]   i_refill_way,
    output logic [`LSU_DATA_W-1:0]     o_rd_word
);

    localparam int WORD_W  = `LSU_DC_LINE_W - 2;
    localparam int ADDR_W  = `LSU_DC_INDEX_W + `LSU_DC_WAY_W + WORD_W;
    localparam int DEPTH   = 1 << ADDR_W;
    localparam int BYTES   = `LSU_DATA_W / 8;
    localparam int IDX_HI  = `LSU_DC_INDEX_W + `LSU_DC_LINE_W - 1;

    logic [`LSU_DATA_W-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0]       rd_addr, rf_addr;
    logic [`LSU_DATA_W-1:0]  wdata;
    logic                    store_we;

    // Word address is {index, way, word offset}
    assign rd_addr = {i_stage.addr[IDX_HI:`LSU_DC_LINE_W], i_stage.way,
                      i_stage.addr[`LSU_DC_LINE_W-1:2]};
    assign rf_addr = {i_refill.addr[IDX_HI:`LSU_DC_LINE_W], i_refill_way,
                      i_refill.addr[`LSU_DC_LINE_W-1:2]};

    assign store_we = i_stage.valid && i_stage.is_store && i_stage.hit;

    // Replicate store data across lanes so the mask picks the right bytes
    always_comb begin
        case (i_stage.func)
            LSU_FUNC_SB: wdata = {4{i_stage.data[7:0]}};
            LSU_FUNC_SH: wdata = {2{i_stage.data[15:0]}};
            default:     wdata = i_stage.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (store_we) begin
            for (int b = 0; b < BYTES; b++) begin
                if (i_stage.byte_mask[b]) begin
                    mem[rd_addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (i_refill.valid) begin
            mem[rf_addr] <= i_refill.data;
        end
    end

    assign o_rd_word = mem[rd_addr];

endmodule

// ==== hw/lsu_decode.sv ====
// LSU decode stage: classifies the operation and builds its byte mask
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_decode import lsu_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    input  lsu_req_t    i_req,
    output lsu_stage_t  o_stage
);

    logic                      is_store;
    logic [`LSU_DATA_W/8-1:0]  byte_mask;

    assign is_store = (i_req.func == LSU_FUNC_SB) || (i_req.func == LSU_FUNC_SH) ||
                      (i_req.func == LSU_FUNC_SW);

    // Lane select from size and the low address bits
    always_comb begin
        case (i_req.func)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB:
                byte_mask = 4'b0001 << i_req.addr[1:0];
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH:
                byte_mask = 4'b0011 << {i_req.addr[1], 1'b0};
            default:
                byte_mask = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_stage.valid <= 1'b0;
        end else begin
            o_stage.valid <= i_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        o_stage.func      <= i_req.func;
        o_stage.addr      <= i_req.addr;
        o_stage.rob_tag   <= i_req.rob_tag;
        o_stage.data      <= i_req.data;
        o_stage.is_store  <= is_store;
        o_stage.byte_mask <= byte_mask;
        // Filled in by the tag lookup
        o_stage.hit       <= 1'b0;
        o_stage.way       <= '0;
    end

endmodule

// ==== hw/lsu_pkg.sv ====
// LSU package: operation and line state encodings, stage and port records
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        LSU_FUNC_LB  = 4'h0,
        LSU_FUNC_LH  = 4'h1,
        LSU_FUNC_LW  = 4'h2,
        LSU_FUNC_LBU = 4'h4,
        LSU_FUNC_LHU = 4'h5,
        LSU_FUNC_SB  = 4'h8,
        LSU_FUNC_SH  = 4'h9,
        LSU_FUNC_SW  = 4'ha
    } lsu_func_t;

    // PENDING marks a way reserved by a miss and waiting for its refill
    typedef enum logic [1:0] {
        DC_INVALID = 2'd0,
        DC_PENDING = 2'd1,
        DC_VALID   = 2'd2
    } dc_line_state_t;

    typedef struct packed {
        logic                          valid;
        lsu_func_t                     func;
        logic [`LSU_ADDR_W-1:0]        addr;
        logic [`LSU_ROB_TAG_W-1:0]     rob_tag;
        logic [`LSU_DATA_W-1:0]        data;
    } lsu_req_t;

    typedef struct packed {
        logic                          valid;
        lsu_func_t                     func;
        logic [`LSU_ADDR_W-1:0]        addr;
        logic [`LSU_ROB_TAG_W-1:0]     rob_tag;
        logic [`LSU_DATA_W-1:0]        data;
        logic                          is_store;
        logic [`LSU_DATA_W/8-1:0]      byte_mask;
        logic                          hit;
        logic [`LSU_DC_WAY_W-1:0]      way;
    } lsu_stage_t;

    typedef struct packed {
        logic                          valid;
        logic [`LSU_DATA_W-1:0]        data;
        logic [`LSU_ADDR_W-1:0]        addr;
        logic [`LSU_ROB_TAG_W-1:0]     rob_tag;
    } lsu_wb_t;

    // Line-aligned address of the missing access
    typedef struct packed {
        logic                          valid;
        logic [`LSU_ADDR_W-1:0]        addr;
        logic [`LSU_ROB_TAG_W-1:0]     rob_tag;
    } lsu_miss_t;

    typedef struct packed {
        logic                          valid;
        logic [`LSU_ADDR_W-1:0]        addr;
        logic [`LSU_DATA_W-1:0]        data;
        logic                          last;
    } lsu_refill_t;

endpackage

// ==== hw/lsu_result.sv ====
// LSU result stage: load data extraction and extension, registered writeback and miss
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_result import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  lsu_stage_t              i_stage,
    input  logic [`LSU_DATA_W-1:0]  i_rd_word,
    output lsu_wb_t                 o_wb,
    output lsu_miss_t               o_miss
);

    logic [`LSU_DATA_W-1:0]  shifted;
    logic [`LSU_DATA_W-1:0]  ld_data;

    // Bring the addressed byte or halfword down to bit 0
    assign shifted = i_rd_word >> {i_stage.addr[1:0], 3'b000};

    always_comb begin
        case (i_stage.func)
            LSU_FUNC_LB:  ld_data = {{(`LSU_DATA_W-8){shifted[7]}}, shifted[7:0]};
            LSU_FUNC_LH:  ld_data = {{(`LSU_DATA_W-16){shifted[15]}}, shifted[15:0]};
            LSU_FUNC_LBU: ld_data = {{(`LSU_DATA_W-8){1'b0}}, shifted[7:0]};
            LSU_FUNC_LHU: ld_data = {{(`LSU_DATA_W-16){1'b0}}, shifted[15:0]};
            default:      ld_data = i_rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wb.valid   <= 1'b0;
            o_miss.valid <= 1'b0;
        end else begin
            o_wb.valid   <= i_stage.valid && i_stage.hit && !i_stage.is_store;
            o_miss.valid <= i_stage.valid && !i_stage.hit;
        end
    end

    always_ff @(posedge clk) begin
        o_wb.data      <= ld_data;
        o_wb.addr      <= i_stage.addr;
        o_wb.rob_tag   <= i_stage.rob_tag;
        o_miss.addr    <= {i_stage.addr[`LSU_ADDR_W-1:`LSU_DC_LINE_W], {`LSU_DC_LINE_W{1'b0}}};
        o_miss.rob_tag <= i_stage.rob_tag;
    end

endmodule

// ==== hw/lsu_tag_lookup.sv ====
// LSU tag lookup: tag/state/LRU arrays, hit check, miss allocation and refill validation
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_tag_lookup import lsu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  lsu_stage_t                 i_stage,
    input  lsu_refill_t                i_refill,
    output lsu_stage_t                 o_stage,
    output logic [`LSU_DC_WAY_W-1:0]   o_refill_way
);

    localparam int SETS   = 1 << `LSU_DC_INDEX_W;
    localparam int TAG_LO = `LSU_DC_INDEX_W + `LSU_DC_LINE_W;

    logic [`LSU_DC_TAG_W-1:0]    tag_q   [`LSU_DC_WAYS][SETS];
    dc_line_state_t              state_q [`LSU_DC_WAYS][SETS];
    logic [SETS-1:0]             lru_q;

    logic [`LSU_DC_INDEX_W-1:0]  idx, rf_idx;
    logic [`LSU_DC_TAG_W-1:0]    tag, rf_tag;
    logic [`LSU_DC_WAYS-1:0]     hit_vec, pend_vec, rf_vec, rf_pend;
    logic                        hit, pending, rf_hit;
    logic [`LSU_DC_WAY_W-1:0]    hit_way, pend_way, victim;

    assign idx    = i_stage.addr[TAG_LO-1:`LSU_DC_LINE_W];
    assign tag    = i_stage.addr[`LSU_ADDR_W-1:TAG_LO];
    assign rf_idx = i_refill.addr[TAG_LO-1:`LSU_DC_LINE_W];
    assign rf_tag = i_refill.addr[`LSU_ADDR_W-1:TAG_LO];

    always_comb begin
        for (int w = 0; w < `LSU_DC_WAYS; w++) begin
            hit_vec[w]  = (state_q[w][idx] == DC_VALID) && (tag_q[w][idx] == tag);
            pend_vec[w] = (state_q[w][idx] == DC_PENDING) && (tag_q[w][idx] == tag);
            rf_pend[w]  = (state_q[w][rf_idx] == DC_PENDING);
            rf_vec[w]   = rf_pend[w] && (tag_q[w][rf_idx] == rf_tag);
        end
    end

    assign hit      = |hit_vec;
    assign pending  = |pend_vec;
    assign rf_hit   = |rf_vec;
    assign hit_way  = hit_vec[1];
    assign pend_way = pend_vec[1];
    assign victim   = lru_q[idx];

    // Refill way: matching PENDING tag, otherwise a reserved way, then the LRU way
    always_comb begin
        if (rf_hit)          o_refill_way = rf_vec[1];
        else if (rf_pend[0]) o_refill_way = 1'b0;
        else if (rf_pend[1]) o_refill_way = 1'b1;
        else                 o_refill_way = lru_q[rf_idx];
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int w = 0; w < `LSU_DC_WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    state_q[w][s] <= DC_INVALID;
                end
            end
            lru_q <= '0;
        end else begin
            if (i_stage.valid && hit) begin
                lru_q[idx] <= ~hit_way;
            end else if (i_stage.valid && !pending) begin
                state_q[victim][idx] <= DC_PENDING;
                lru_q[idx]           <= ~victim;
            end
            if (i_refill.valid && i_refill.last && rf_hit) begin
                state_q[o_refill_way][rf_idx] <= DC_VALID;
            end
        end
    end

    // New tag goes in with the allocation
    always_ff @(posedge clk) begin
        if (i_stage.valid && !hit && !pending) begin
            tag_q[victim][idx] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_stage.valid <= 1'b0;
        end else begin
            o_stage.valid <= i_stage.valid;
        end
    end

    always_ff @(posedge clk) begin
        o_stage.func      <= i_stage.func;
        o_stage.addr      <= i_stage.addr;
        o_stage.rob_tag   <= i_stage.rob_tag;
        o_stage.data      <= i_stage.data;
        o_stage.is_store  <= i_stage.is_store;
        o_stage.byte_mask <= i_stage.byte_mask;
        o_stage.hit       <= hit;
        o_stage.way       <= hit ? hit_way : (pending ? pend_way : victim);
    end

endmodule

// ==== hw/lsu_top.sv ====
// LSU top: decode, tag lookup, data array and result stages of the load/store pipeline
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_top import lsu_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,
    input  lsu_req_t     i_req,
    input  lsu_refill_t  i_refill,
    output lsu_wb_t      o_wb,
    output lsu_miss_t    o_miss
);

    lsu_stage_t                 stage1;
    lsu_stage_t                 stage2;
    logic [`LSU_DC_WAY_W-1:0]   refill_way;
    logic [`LSU_DATA_W-1:0]     rd_word;

    lsu_decode u_decode (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_req    (i_req),
        .o_stage  (stage1)
    );

    lsu_tag_lookup u_tag_lookup (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stage       (stage1),
        .i_refill      (i_refill),
        .o_stage       (stage2),
        .o_refill_way  (refill_way)
    );

    // Load word read belongs to stage 2
    lsu_data_array u_data_array (
        .clk           (clk),
        .i_stage       (stage2),
        .i_refill      (i_refill),
        .i_refill_way  (refill_way),
        .o_rd_word     (rd_word)
    );

    lsu_result u_result (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stage    (stage2),
        .i_rd_word  (rd_word),
        .o_wb       (o_wb),
        .o_miss     (o_miss)
    );

endmodule

// ==== lsu.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/lsu_tag_lookup.sv
hw/lsu_data_array.sv
hw/lsu_result.sv
hw/lsu_top.sv
tests/lsu_chk.sv
tests/lsu_monitor.sv
tests/tb_lsu.sv

// ==== tests/lsu_chk.sv ====
// LSU protocol checks: exclusive output strobes, refill on an empty pipeline, reset state
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_chk import lsu_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,
    input  lsu_refill_t  i_refill,
    input  lsu_wb_t      i_wb,
    input  lsu_miss_t    i_miss,
    input  lsu_stage_t   i_stage1,
    input  lsu_stage_t   i_stage2
);

    int fail_cnt = 0;

    a_one_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_wb.valid && i_miss.valid))
    else begin
        $error("o_wb and o_miss valid in the same cycle");
        fail_cnt++;
    end

    // Refill words only while both pipeline stages are empty
    a_refill_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_refill.valid |-> !i_stage1.valid && !i_stage2.valid)
    else begin
        $error("Refill word arrived with an operation in the pipeline");
        fail_cnt++;
    end

    a_reset_quiet: assert property (@(posedge clk)
        !i_rst_n |=> !i_wb.valid && !i_miss.valid)
    else begin
        $error("Output strobe valid right after reset");
        fail_cnt++;
    end

endmodule

bind lsu_top lsu_chk u_chk (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_refill (i_refill),
    .i_wb     (o_wb),
    .i_miss   (o_miss),
    .i_stage1 (stage1),
    .i_stage2 (stage2)
);

// ==== tests/lsu_monitor.sv ====
// LSU monitor: reference tag model, expected results and comparison with the DUT outputs
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_monitor import lsu_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,
    input  lsu_req_t     i_req,
    input  lsu_refill_t  i_refill,
    input  lsu_wb_t      i_wb,
    input  lsu_miss_t    i_miss
);

    localparam int SETS   = 1 << `LSU_DC_INDEX_W;
    localparam int TAG_LO = `LSU_DC_INDEX_W + `LSU_DC_LINE_W;

    typedef struct packed {
        logic                       wb;
        logic                       miss;
        logic [`LSU_DATA_W-1:0]     data;
        logic [`LSU_ADDR_W-1:0]     addr;
        logic [`LSU_ROB_TAG_W-1:0]  rob_tag;
    } expect_t;

    logic [`LSU_DC_TAG_W-1:0]  ref_tag   [`LSU_DC_WAYS][SETS];
    dc_line_state_t            ref_state [`LSU_DC_WAYS][SETS];
    logic                      ref_lru   [SETS];
    // Expected results of the three operations in flight, oldest last
    expect_t                   exp_q [3];
    int                        err_cnt = 0;
    int                        chk_cnt = 0;

    // Little-endian bytes from the testbench memory, extended by load kind
    function automatic logic [31:0] load_value(lsu_func_t func, logic [31:0] addr);
        logic [7:0] b [4];
        for (int i = 0; i < 4; i++) begin
            b[i] = tb_lsu.mem[addr[10:0] + 11'(i)];
        end
        case (func)
            LSU_FUNC_LB:  return {{24{b[0][7]}}, b[0]};
            LSU_FUNC_LBU: return {24'h0, b[0]};
            LSU_FUNC_LH:  return {{16{b[1][7]}}, b[1], b[0]};
            LSU_FUNC_LHU: return {16'h0, b[1], b[0]};
            default:      return {b[3], b[2], b[1], b[0]};
        endcase
    endfunction

    // Hit, PENDING and allocation rules applied to the reference tags
    function automatic expect_t predict(lsu_req_t req);
        expect_t                     e;
        logic [`LSU_DC_INDEX_W-1:0]  idx;
        logic [`LSU_DC_TAG_W-1:0]    tag;
        logic                        hit;
        logic                        pend;
        logic                        store;
        int                          way;
        idx   = req.addr[TAG_LO-1:`LSU_DC_LINE_W];
        tag   = req.addr[`LSU_ADDR_W-1:TAG_LO];
        store = req.func inside {LSU_FUNC_SB, LSU_FUNC_SH, LSU_FUNC_SW};
        hit   = 1'b0;
        pend  = 1'b0;
        way   = 0;
        for (int w = 0; w < `LSU_DC_WAYS; w++) begin
            if (ref_state[w][idx] == DC_VALID && ref_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = w;
            end
            if (ref_state[w][idx] == DC_PENDING && ref_tag[w][idx] == tag) begin
                pend = 1'b1;
            end
        end
        if (hit) begin
            ref_lru[idx] = (way == 0);
        end else if (!pend) begin
            way                 = ref_lru[idx];
            ref_tag[way][idx]   = tag;
            ref_state[way][idx] = DC_PENDING;
            ref_lru[idx]        = (way == 0);
        end
        e.wb      = hit && !store;
        e.miss    = !hit;
        e.data    = load_value(req.func, req.addr);
        e.addr    = req.addr;
        e.rob_tag = req.rob_tag;
        return e;
    endfunction

    function automatic void validate_line(logic [`LSU_ADDR_W-1:0] addr);
        logic [`LSU_DC_INDEX_W-1:0]  idx;
        logic [`LSU_DC_TAG_W-1:0]    tag;
        idx = addr[TAG_LO-1:`LSU_DC_LINE_W];
        tag = addr[`LSU_ADDR_W-1:TAG_LO];
        for (int w = 0; w < `LSU_DC_WAYS; w++) begin
            if (ref_state[w][idx] == DC_PENDING && ref_tag[w][idx] == tag) begin
                ref_state[w][idx] = DC_VALID;
            end
        end
    endfunction

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        err_cnt++;
        $display("ERROR %s: expected %h, got %h at %0t ns", name, exp, got, $time);
    endtask

    task automatic compare_outputs(expect_t e);
        logic [`LSU_ADDR_W-1:0] line;
        line = {e.addr[`LSU_ADDR_W-1:`LSU_DC_LINE_W], {`LSU_DC_LINE_W{1'b0}}};
        chk_cnt++;
        if (i_wb.valid !== e.wb) begin
            report_mismatch("o_wb.valid", e.wb, i_wb.valid);
        end
        if (i_miss.valid !== e.miss) begin
            report_mismatch("o_miss.valid", e.miss, i_miss.valid);
        end
        if (e.wb && i_wb.valid) begin
            if (i_wb.data !== e.data) begin
                report_mismatch("o_wb.data", e.data, i_wb.data);
            end
            if (i_wb.addr !== e.addr) begin
                report_mismatch("o_wb.addr", e.addr, i_wb.addr);
            end
            if (i_wb.rob_tag !== e.rob_tag) begin
                report_mismatch("o_wb.rob_tag", e.rob_tag, i_wb.rob_tag);
            end
        end
        if (e.miss && i_miss.valid) begin
            if (i_miss.addr !== line) begin
                report_mismatch("o_miss.addr", line, i_miss.addr);
            end
            if (i_miss.rob_tag !== e.rob_tag) begin
                report_mismatch("o_miss.rob_tag", e.rob_tag, i_miss.rob_tag);
            end
        end
    endtask

    // Outputs are read before this edge updates them, three edges after issue
    always @(posedge clk) begin
        if (!i_rst_n) begin
            for (int w = 0; w < `LSU_DC_WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    ref_state[w][s] = DC_INVALID;
                end
            end
            ref_lru = '{default: 1'b0};
            exp_q   = '{default: '0};
        end else begin
            compare_outputs(exp_q[2]);
            exp_q[2] = exp_q[1];
            exp_q[1] = exp_q[0];
            exp_q[0] = i_req.valid ? predict(i_req) : expect_t'('0);
            if (i_refill.valid && i_refill.last) begin
                validate_line(i_refill.addr);
            end
        end
    end

endmodule

// ==== tests/tb_lsu.sv ====
// LSU testbench: clock, reset, directed and random operations, memory model as refill source
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module tb_lsu import lsu_pkg::*; ();

    localparam int MEM_BYTES   = 2048;
    localparam int LINE_WORDS  = 1 << (`LSU_DC_LINE_W - 2);
    localparam int TAG_LO      = `LSU_DC_INDEX_W + `LSU_DC_LINE_W;
    localparam int N_DIRECT    = 32;
    localparam int N_RAND      = 320;
    localparam int BURST_LEN   = 8;
    // Worst case cycles per operation with issue, drain, refill, replay and second drain
    localparam int OP_CYCLES   = 26;
    localparam int CYCLE_LIMIT = 2 * (N_DIRECT + N_RAND) * OP_CYCLES + 400;

    logic                              clk;
    logic                              rst_n;
    lsu_req_t                          req;
    lsu_refill_t                       refill;
    lsu_wb_t                           wb;
    lsu_miss_t                         miss;

    // Byte memory behind the cache with three tags per set in the random window
    logic [7:0]                        mem [MEM_BYTES];
    lsu_req_t                          burst_q [$];
    logic [`LSU_ADDR_W-1:0]            miss_lines [$];
    logic [(1<<`LSU_ROB_TAG_W)-1:0]    missed;
    logic [`LSU_ROB_TAG_W-1:0]         next_tag;
    lsu_func_t                         all_funcs [8] = '{LSU_FUNC_LB, LSU_FUNC_LH, LSU_FUNC_LW,
                                                         LSU_FUNC_LBU, LSU_FUNC_LHU, LSU_FUNC_SB,
                                                         LSU_FUNC_SH, LSU_FUNC_SW};
    int                                tb_errors = 0;
    int                                cycles = 0;
    int                                total_errors;

    lsu_top dut_i (
        .clk      (clk),
        .i_rst_n  (rst_n),
        .i_req    (req),
        .i_refill (refill),
        .o_wb     (wb),
        .o_miss   (miss)
    );

    lsu_monitor u_monitor (
        .clk      (clk),
        .i_rst_n  (rst_n),
        .i_req    (req),
        .i_refill (refill),
        .i_wb     (wb),
        .i_miss   (miss)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic bit line_listed(logic [`LSU_ADDR_W-1:0] line);
        foreach (miss_lines[i]) begin
            if (miss_lines[i] == line) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // A line evicted again before its refill has no reserved way and is left to the replay
    function automatic bit line_reserved(logic [`LSU_ADDR_W-1:0] line);
        logic [`LSU_DC_INDEX_W-1:0]  idx;
        logic [`LSU_DC_TAG_W-1:0]    tag;
        idx = line[TAG_LO-1:`LSU_DC_LINE_W];
        tag = line[`LSU_ADDR_W-1:TAG_LO];
        for (int w = 0; w < `LSU_DC_WAYS; w++) begin
            if (u_monitor.ref_state[w][idx] == DC_PENDING &&
                u_monitor.ref_tag[w][idx] == tag) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Miss strobes name the lines to refill and the operations to replay
    always @(posedge clk) begin
        if (rst_n && miss.valid) begin
            missed[miss.rob_tag] = 1'b1;
            if (!line_listed(miss.addr)) begin
                miss_lines.push_back(miss.addr);
            end
        end
    end

    function automatic lsu_req_t make_op(lsu_func_t func, logic [31:0] addr, logic [31:0] data);
        lsu_req_t op;
        op.valid   = 1'b1;
        op.func    = func;
        op.addr    = addr;
        op.rob_tag = next_tag;
        op.data    = data;
        next_tag++;
        return op;
    endfunction

    function automatic lsu_req_t random_op();
        lsu_func_t    func;
        logic [31:0]  addr;
        func = all_funcs[$urandom % 8];
        addr = (($urandom % 3) << 9) | (($urandom % 4) << 5) | ($urandom % 32);
        if (func inside {LSU_FUNC_LW, LSU_FUNC_SW}) begin
            addr[1:0] = 2'b00;
        end else if (func inside {LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH}) begin
            addr[0] = 1'b0;
        end
        return make_op(func, addr, $urandom);
    endfunction

    task automatic update_memory(lsu_req_t op);
        int nbytes;
        case (op.func)
            LSU_FUNC_SB: nbytes = 1;
            LSU_FUNC_SH: nbytes = 2;
            LSU_FUNC_SW: nbytes = 4;
            default:     nbytes = 0;
        endcase
        for (int b = 0; b < nbytes; b++) begin
            mem[op.addr[10:0] + 11'(b)] = op.data[8*b +: 8];
        end
    endtask

    task automatic issue(lsu_req_t op);
        req = op;
        update_memory(op);
        burst_q.push_back(op);
        @(negedge clk);
    endtask

    task automatic drain();
        req.valid = 1'b0;
        repeat (5) @(negedge clk);
    endtask

    task automatic refill_line(logic [`LSU_ADDR_W-1:0] line);
        logic [10:0] a;
        for (int w = 0; w < LINE_WORDS; w++) begin
            a             = line[10:0] + 11'(4 * w);
            refill.valid  = 1'b1;
            refill.addr   = line + 4 * w;
            refill.data   = {mem[a + 11'd3], mem[a + 11'd2], mem[a + 11'd1], mem[a]};
            refill.last   = (w == LINE_WORDS - 1);
            @(negedge clk);
        end
        refill.valid = 1'b0;
        refill.last  = 1'b0;
        @(negedge clk);
    endtask

    // Runs one operation alone in the pipeline and retries it once after a refill
    task automatic replay_one(lsu_req_t op);
        for (int tries = 0; tries < 2; tries++) begin
            missed[op.rob_tag] = 1'b0;
            miss_lines.delete();
            issue(op);
            drain();
            if (!missed[op.rob_tag]) begin
                return;
            end
            refill_line(miss_lines[0]);
        end
        tb_errors++;
        $display("Replayed operation with rob tag %0d still misses after its line refill",
                 op.rob_tag);
    endtask

    task automatic settle_burst();
        lsu_req_t                ops [$];
        logic [`LSU_ADDR_W-1:0]  lines [$];
        drain();
        lines = miss_lines;
        ops   = burst_q;
        foreach (lines[i]) begin
            if (line_reserved(lines[i])) begin
                refill_line(lines[i]);
            end
        end
        foreach (ops[i]) begin
            if (missed[ops[i].rob_tag]) begin
                replay_one(ops[i]);
            end
        end
        burst_q.delete();
        miss_lines.delete();
        missed = '0;
    endtask

    initial begin
        void'($urandom(32'h1ae6));
        rst_n    = 1'b0;
        req      = '0;
        refill   = '0;
        missed   = '0;
        next_tag = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'((i * 29) ^ (i >> 8));
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // First touch of two lines
        issue(make_op(LSU_FUNC_LW, 32'h000, '0));
        issue(make_op(LSU_FUNC_LBU, 32'h025, '0));
        settle_burst();

        // All five load kinds on refilled lines
        issue(make_op(LSU_FUNC_LB, 32'h003, '0));
        issue(make_op(LSU_FUNC_LH, 32'h002, '0));
        issue(make_op(LSU_FUNC_LW, 32'h004, '0));
        issue(make_op(LSU_FUNC_LBU, 32'h007, '0));
        issue(make_op(LSU_FUNC_LHU, 32'h00e, '0));
        issue(make_op(LSU_FUNC_LB, 32'h025, '0));
        settle_burst();

        // Store hits of each size read back on the next cycle
        issue(make_op(LSU_FUNC_SB, 32'h011, 32'h0000_00a5));
        issue(make_op(LSU_FUNC_LW, 32'h010, '0));
        issue(make_op(LSU_FUNC_SH, 32'h016, 32'h0000_8001));
        issue(make_op(LSU_FUNC_LH, 32'h016, '0));
        issue(make_op(LSU_FUNC_LHU, 32'h016, '0));
        issue(make_op(LSU_FUNC_SW, 32'h01c, 32'hdead_beef));
        issue(make_op(LSU_FUNC_LB, 32'h01f, '0));
        issue(make_op(LSU_FUNC_LBU, 32'h01c, '0));
        issue(make_op(LSU_FUNC_SB, 32'h003, 32'h0000_0080));
        issue(make_op(LSU_FUNC_LB, 32'h003, '0));
        settle_burst();

        // Second miss to a PENDING line in set 0 keeps the other way
        issue(make_op(LSU_FUNC_LW, 32'h200, '0));
        issue(make_op(LSU_FUNC_LH, 32'h204, '0));
        issue(make_op(LSU_FUNC_LW, 32'h000, '0));
        settle_burst();

        // Third tag evicts the LRU way and the evicted line misses again
        issue(make_op(LSU_FUNC_LW, 32'h400, '0));
        issue(make_op(LSU_FUNC_LW, 32'h000, '0));
        issue(make_op(LSU_FUNC_LW, 32'h200, '0));
        settle_burst();

        for (int b = 0; b < N_RAND / BURST_LEN; b++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                issue(random_op());
            end
            settle_burst();
        end

        repeat (4) @(negedge clk);
        total_errors = u_monitor.err_cnt + tb_errors + dut_i.u_chk.fail_cnt;
        $display("Checks %0d, errors: monitor %0d, testbench %0d, assertions %0d",
                 u_monitor.chk_cnt, u_monitor.err_cnt, tb_errors, dut_i.u_chk.fail_cnt);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
